// ==== build.f ====
+incdir+design
design/snoop_pkg.sv
design/mem_write_if.sv
design/axis_snooper.sv
design/snoop_width_adapter.sv
design/packet_buffer.sv
design/snoop_top.sv
sim/tb_snoop_top.sv

// ==== design/axis_snooper.sv ====
`include "snoop_defs.svh"

module axis_snooper (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`SNOOP_DATA_W-1:0] s_tdata_i,
   input  logic [`SNOOP_KEEP_W-1:0] s_tkeep_i,
   input  logic                     s_tvalid_i,
   input  logic                     s_tready_i,
   input  logic                     s_tlast_i,
   input  logic                     buf_free_i,
   output logic                     claim_ack_o,
   output logic [15:0]              drop_count_o,
   mem_write_if.source              wr
);
   import snoop_pkg::*;

   snoop_state_e state_q;
   snoop_state_e state_d;
   // Seen a beat without TLAST since the last TLAST
   logic mid_packet_q;
   fwd_addr_t addr_q;
   fwd_inc_t keep_count;
   logic [15:0] drop_count_q;
   // Beat actually transferred on the observed link
   logic beat;
   logic claim;
   logic capture;
   logic drop;

   assign beat = s_tvalid_i && s_tready_i;

   // Join only on a packet boundary with the buffer free
   assign claim = (state_q == not_started) && buf_free_i && !mid_packet_q && beat;
   // The claiming beat is stored as well
   assign capture = ((state_q == started) && beat) || claim;
   // Final beat of a packet that was not stored
   assign drop = beat && s_tlast_i && !capture;

   always_comb begin
      state_d = state_q;
      case (state_q)
         not_started: begin
            if (claim) begin
               // Single-beat packet ends right away
               state_d = s_tlast_i ? not_started : started;
            end else if (buf_free_i && mid_packet_q && !(beat && s_tlast_i)) begin
               state_d = waiting;
            end
         end
         waiting: begin
            // Wait for the running packet to finish
            if (beat && s_tlast_i) begin
               state_d = not_started;
            end
         end
         started: begin
            if (beat && s_tlast_i) begin
               state_d = not_started;
            end
         end
         default: begin
            state_d = not_started;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= not_started;
         mid_packet_q <= 1'b0;
         addr_q       <= '0;
         drop_count_q <= '0;
      end else begin
         state_q <= state_d;
         if (beat) begin
            mid_packet_q <= !s_tlast_i;
         end
         // Beat counter restarts for every packet
         if (capture) begin
            addr_q <= s_tlast_i ? '0 : addr_q + 1'b1;
         end
         // Saturating drop counter
         if (drop && !(&drop_count_q)) begin
            drop_count_q <= drop_count_q + 1'b1;
         end
      end
   end

   // TKEEP popcount
   always_comb begin
      keep_count = '0;
      for (int i = 0; i < `SNOOP_KEEP_W; i++) begin
         keep_count = keep_count + fwd_inc_t'(s_tkeep_i[i]);
      end
   end

   assign claim_ack_o  = claim;
   assign drop_count_o = drop_count_q;

   // Stream-width write port, straight from the link
   assign wr.addr     = addr_q;
   assign wr.wr_data  = s_tdata_i;
   assign wr.wr_en    = capture;
   assign wr.byte_inc = keep_count;
   assign wr.done     = capture && s_tlast_i;

   // Keep bytes packed from byte 0
   a_keep_contiguous : assert property (@(posedge clk) disable iff (rst)
      beat |-> s_tkeep_i[0] && ((s_tkeep_i & (s_tkeep_i + 1'b1)) == '0))
      else $error("TKEEP not contiguous from bit 0: %h", s_tkeep_i);

   // Only the last beat may be partial
   a_keep_full : assert property (@(posedge clk) disable iff (rst)
      beat && !s_tlast_i |-> &s_tkeep_i)
      else $error("Partial TKEEP on a beat without TLAST: %h", s_tkeep_i);

   a_state_legal : assert property (@(posedge clk) disable iff (rst)
      state_q inside {not_started, waiting, started})
      else $error("Snooper state took the unused encoding");
endmodule

// ==== design/mem_write_if.sv ====
`include "snoop_defs.svh"

// Write port between snooper, width adapter and packet buffer
// No back-pressure, the sink takes every write
interface mem_write_if #(
   parameter int DATA_W = `SNOOP_DATA_W,
   parameter int ADDR_W = `FWD_ADDR_W,
   parameter int INC_W  = 4
);
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wr_data;
   // One write per cycle with wr_en high
   logic wr_en;
   // Valid bytes carried by this write
   logic [INC_W-1:0] byte_inc;
   // Marks the final write of a packet
   logic done;

   modport source (
      output addr,
      output wr_data,
      output wr_en,
      output byte_inc,
      output done
   );

   modport sink (
      input addr,
      input wr_data,
      input wr_en,
      input byte_inc,
      input done
   );
endinterface

// ==== design/packet_buffer.sv ====
`include "snoop_defs.svh"

module packet_buffer (
   input  logic                   clk,
   input  logic                   rst,
   mem_write_if.sink              wr,
   input  logic                   claim_ack_i,
   output logic                   buf_free_o,
   output logic                   pkt_valid_o,
   output snoop_pkg::pkt_len_t    pkt_len_o,
   input  snoop_pkg::mem_addr_t   rd_addr_i,
   output logic [`MEM_DATA_W-1:0] rd_data_o,
   input  logic                   pkt_release_i
);
   import snoop_pkg::*;

   // Packet storage, one word per beat pair
   logic [`MEM_DATA_W-1:0] mem [2**`MEM_ADDR_W];
   // Running byte count of the packet
   pkt_len_t len_q;
   // Empty and not claimed by the snooper
   logic buf_free_q;
   // Complete packet held for the reader
   logic pkt_valid_q;
   logic release_ok;

   // Release is ignored unless a packet is held
   assign release_ok = pkt_release_i && pkt_valid_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         buf_free_q  <= 1'b1;
         pkt_valid_q <= 1'b0;
         len_q       <= '0;
      end else begin
         if (claim_ack_i) begin
            buf_free_q <= 1'b0;
         end
         if (wr.wr_en) begin
            len_q <= len_q + pkt_len_t'(wr.byte_inc);
         end
         // Packet complete after its final word
         if (wr.done) begin
            pkt_valid_q <= 1'b1;
         end
         // Reader hands the buffer back
         if (release_ok) begin
            pkt_valid_q <= 1'b0;
            buf_free_q  <= 1'b1;
            len_q       <= '0;
         end
      end
   end

   // Word RAM with registered read
   always_ff @(posedge clk) begin
      if (wr.wr_en) begin
         mem[wr.addr] <= wr.wr_data;
      end
      rd_data_o <= mem[rd_addr_i];
   end

   assign buf_free_o  = buf_free_q;
   assign pkt_valid_o = pkt_valid_q;
   // Final once pkt_valid_o is up
   assign pkt_len_o   = len_q;

   // Held packet must stay untouched until released
   a_no_write_held : assert property (@(posedge clk) disable iff (rst)
      wr.wr_en |-> !pkt_valid_q)
      else $error("Buffer write at %h while a packet is held", wr.addr);

   // Earlier words are all full, 16 bytes each
   // A packet past the last entry wraps and breaks this
   a_addr_in_range : assert property (@(posedge clk) disable iff (rst)
      wr.wr_en |-> len_q == {1'b0, wr.addr, 4'h0})
      else $error("Write address %h past buffer end or out of order, length %h",
                  wr.addr, len_q);
endmodule

// ==== design/snoop_defs.svh ====
`ifndef SNOOP_DEFS_SVH
`define SNOOP_DEFS_SVH

// Stream side of the tap
`define SNOOP_DATA_W 64
// One keep bit per stream byte
`define SNOOP_KEEP_W 8

// Packet buffer word, twice the stream width
`define MEM_DATA_W 128
// 64 words, 1024 bytes
`define MEM_ADDR_W 6

// Beat index inside one packet
`define FWD_ADDR_W 7
// Byte length of a full buffer, plus one bit of headroom
`define PKT_LEN_W 11

`endif

// ==== design/snoop_pkg.sv ====
`include "snoop_defs.svh"

package snoop_pkg;

   // Capture FSM states
   // Encoding 2'b10 is never used
   typedef enum logic [1:0] {
      not_started = 2'b00,
      waiting     = 2'b01,
      started     = 2'b11
   } snoop_state_e;

   // Beat address on the stream-width write port
   typedef logic [`FWD_ADDR_W-1:0] fwd_addr_t;
   // Word address into the packet buffer
   typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

   // Bytes per stream beat, 0 to 8
   typedef logic [3:0] fwd_inc_t;
   // Bytes per buffer word, 0 to 16
   typedef logic [4:0] mem_inc_t;

   // Total bytes of the captured packet
   typedef logic [`PKT_LEN_W-1:0] pkt_len_t;

endpackage

// ==== design/snoop_top.sv ====
`include "snoop_defs.svh"

module snoop_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`SNOOP_DATA_W-1:0] s_tdata_i,
   input  logic [`SNOOP_KEEP_W-1:0] s_tkeep_i,
   input  logic                     s_tvalid_i,
   input  logic                     s_tready_i,
   input  logic                     s_tlast_i,
   output logic                     pkt_valid_o,
   output snoop_pkg::pkt_len_t      pkt_len_o,
   input  snoop_pkg::mem_addr_t     rd_addr_i,
   output logic [`MEM_DATA_W-1:0]   rd_data_o,
   input  logic                     pkt_release_i,
   output logic [15:0]              drop_count_o
);
   import snoop_pkg::*;

   // Buffer ownership handshake
   logic buf_free;
   logic claim_ack;

   // Beat writes from the snooper
   mem_write_if #(
      .DATA_W (`SNOOP_DATA_W),
      .ADDR_W ($bits(fwd_addr_t)),
      .INC_W  ($bits(fwd_inc_t))
   ) fwd_wr ();

   // Packed word writes into the buffer
   mem_write_if #(
      .DATA_W (`MEM_DATA_W),
      .ADDR_W ($bits(mem_addr_t)),
      .INC_W  ($bits(mem_inc_t))
   ) mem_wr ();

   axis_snooper u_snooper (
      .clk          (clk),
      .rst          (rst),
      .s_tdata_i    (s_tdata_i),
      .s_tkeep_i    (s_tkeep_i),
      .s_tvalid_i   (s_tvalid_i),
      .s_tready_i   (s_tready_i),
      .s_tlast_i    (s_tlast_i),
      .buf_free_i   (buf_free),
      .claim_ack_o  (claim_ack),
      .drop_count_o (drop_count_o),
      .wr           (fwd_wr.source)
   );

   snoop_width_adapter u_adapter (
      .clk (clk),
      .rst (rst),
      .in  (fwd_wr.sink),
      .out (mem_wr.source)
   );

   packet_buffer u_buffer (
      .clk           (clk),
      .rst           (rst),
      .wr            (mem_wr.sink),
      .claim_ack_i   (claim_ack),
      .buf_free_o    (buf_free),
      .pkt_valid_o   (pkt_valid_o),
      .pkt_len_o     (pkt_len_o),
      .rd_addr_i     (rd_addr_i),
      .rd_data_o     (rd_data_o),
      .pkt_release_i (pkt_release_i)
   );
endmodule

// ==== design/snoop_width_adapter.sv ====
`include "snoop_defs.svh"

module snoop_width_adapter (
   input  logic        clk,
   input  logic        rst,
   mem_write_if.sink   in,
   mem_write_if.source out
);
   import snoop_pkg::*;

   // Even beat waiting for its partner
   logic [`SNOOP_DATA_W-1:0] low_data_q;
   fwd_inc_t low_inc_q;
   // Address the next stream write should carry
   fwd_addr_t exp_addr_q;
   // Beat index parity within the packet
   logic odd_beat;

   assign odd_beat = in.addr[0];

   // Park even beats in the lower half
   always_ff @(posedge clk) begin
      if (in.wr_en && !odd_beat) begin
         low_data_q <= in.wr_data;
         low_inc_q  <= in.byte_inc;
      end
   end

   // Strobes of the buffer-width port
   always_ff @(posedge clk) begin
      if (rst) begin
         out.wr_en <= 1'b0;
         out.done  <= 1'b0;
      end else begin
         // Pair complete, or packet ends on an even beat
         out.wr_en <= in.wr_en && (odd_beat || in.done);
         out.done  <= in.wr_en && in.done;
      end
   end

   // Word payload
   always_ff @(posedge clk) begin
      if (in.wr_en) begin
         // Two beats per word
         out.addr <= in.addr[`FWD_ADDR_W-1:1];
         if (odd_beat) begin
            out.wr_data  <= {in.wr_data, low_data_q};
            out.byte_inc <= mem_inc_t'(low_inc_q) + mem_inc_t'(in.byte_inc);
         end else begin
            // Lone final beat, upper half stays zero
            out.wr_data  <= {{`SNOOP_DATA_W{1'b0}}, in.wr_data};
            out.byte_inc <= mem_inc_t'(in.byte_inc);
         end
      end
   end

   // Expected beat address, back to 0 after each packet
   always_ff @(posedge clk) begin
      if (rst) begin
         exp_addr_q <= '0;
      end else if (in.wr_en) begin
         exp_addr_q <= in.done ? '0 : in.addr + 1'b1;
      end
   end

   // Pairing relies on gapless beat addresses from the snooper
   a_addr_step : assert property (@(posedge clk) disable iff (rst)
      in.wr_en |-> in.addr == exp_addr_q)
      else $error("Beat address %h, expected %h", in.addr, exp_addr_q);
endmodule

// ==== sim/snoop_input.txt ====
# P flag: packet header, 1 captured, 0 dropped; H n: hold the next release n cycles
# B valid ready last keep data: one stream cycle in hex; I n: n idle cycles plus a random gap
P 1
B 1 1 0 ff 0011223344556677
B 1 1 0 ff 8899aabbccddeeff
B 1 1 0 ff 0123456789abcdef
B 1 1 1 ff fedcba9876543210
I 2
P 1
B 1 1 0 ff a0a0a0a0a0a0a0a0
B 1 0 0 ff deadbeefdeadbeef
B 1 1 0 ff a1a1a1a1a1a1a1a1
B 1 1 1 07 0000000000a2a2a2
I 1
P 1
B 1 1 1 01 00000000000000c5
I 1
P 1
H 30
B 1 1 0 ff 1111111111111111
B 1 1 1 ff 2222222222222222
I 1
P 0
B 1 1 0 ff 3333333333333333
B 1 1 1 3f 0000444444444444
I 2
P 0
B 1 1 0 ff 5555555555555555
I 20
I 20
B 1 1 1 0f 0000000066666666
I 1
P 1
B 1 1 0 ff 7777777777777777
B 1 0 0 ff 0badc0de0badc0de
B 1 1 0 ff 8888888888888888
B 1 1 1 ff 9999999999999999
I 3

// ==== sim/tb_snoop_top.sv ====
`include "snoop_defs.svh"

module tb_snoop_top;
   import snoop_pkg::*;

   logic clk = 1'b0;
   logic rst;
   logic [`SNOOP_DATA_W-1:0] s_tdata_i;
   logic [`SNOOP_KEEP_W-1:0] s_tkeep_i;
   logic s_tvalid_i;
   logic s_tready_i;
   logic s_tlast_i;
   logic pkt_valid_o;
   pkt_len_t pkt_len_o;
   mem_addr_t rd_addr_i;
   logic [`MEM_DATA_W-1:0] rd_data_o;
   logic pkt_release_i;
   logic [15:0] drop_count_o;

   // Expected words, word counts and lengths of captured packets, in order
   logic [`MEM_DATA_W-1:0] exp_words[$];
   int exp_nwords[$];
   int exp_len[$];
   string stim_lines[$];
   // Extra cycles before the next release
   int hold_cycles = 0;
   // Buffer handed back by the reader
   bit buf_released = 1'b1;
   bit reader_busy = 1'b0;
   int errors = 0;
   int cycle_count = 0;
   int cycle_limit = 0;

   snoop_top dut (
      .clk           (clk),
      .rst           (rst),
      .s_tdata_i     (s_tdata_i),
      .s_tkeep_i     (s_tkeep_i),
      .s_tvalid_i    (s_tvalid_i),
      .s_tready_i    (s_tready_i),
      .s_tlast_i     (s_tlast_i),
      .pkt_valid_o   (pkt_valid_o),
      .pkt_len_o     (pkt_len_o),
      .rd_addr_i     (rd_addr_i),
      .rd_data_o     (rd_data_o),
      .pkt_release_i (pkt_release_i),
      .drop_count_o  (drop_count_o)
   );

   always #20 clk = ~clk;

   // Run limit from the file length
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, errors so far: %0d", cycle_count, errors);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [`MEM_DATA_W-1:0] got,
                              input logic [`MEM_DATA_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Bytes marked valid by TKEEP
   function automatic int keep_bytes(input logic [`SNOOP_KEEP_W-1:0] keep);
      int n;
      n = 0;
      for (int i = 0; i < `SNOOP_KEEP_W; i++) begin
         n += keep[i];
      end
      return n;
   endfunction

   task automatic drive_cycle(input logic valid, input logic ready, input logic last,
                              input logic [`SNOOP_KEEP_W-1:0] keep,
                              input logic [`SNOOP_DATA_W-1:0] data);
      @(negedge clk);
      s_tvalid_i = valid;
      s_tready_i = ready;
      s_tlast_i  = last;
      s_tkeep_i  = keep;
      s_tdata_i  = data;
   endtask

   // Reads the file into a line queue and sums a cycle budget
   task automatic load_stimulus(output int budget);
      int fd;
      int n;
      int got;
      string line;
      budget = 0;
      fd = $fopen("sim/snoop_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file sim/snoop_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            // Skip comments and blank lines
            if (got > 1 && line.getc(0) != "#") begin
               stim_lines.push_back(line);
               got = $sscanf(line.substr(1, line.len() - 1), "%d", n);
               case (line.getc(0))
                  "B": budget += 2;
                  "I": budget += n + 2;
                  "H": budget += n;
                  default: budget += 4;
               endcase
            end
         end
         $fclose(fd);
      end
   endtask

   // Drives the stream and builds expected buffer words
   task automatic run_stimulus(output int drops);
      logic [`MEM_DATA_W-1:0] word;
      logic [`SNOOP_KEEP_W-1:0] keep;
      logic [`SNOOP_DATA_W-1:0] data;
      string body;
      int got;
      int v;
      int r;
      int l;
      int n;
      int flag;
      int beats;
      int len;
      int words;
      drops = 0;
      flag = 0;
      beats = 0;
      len = 0;
      words = 0;
      word = '0;
      foreach (stim_lines[i]) begin
         body = stim_lines[i].substr(1, stim_lines[i].len() - 1);
         case (stim_lines[i].getc(0))
            "P": begin
               got = $sscanf(body, "%d", flag);
               // Captured packet starts only once the buffer is back
               if (flag != 0) begin
                  while (!buf_released) @(negedge clk);
                  buf_released = 1'b0;
               end
               beats = 0;
               len = 0;
               words = 0;
            end
            "H": got = $sscanf(body, "%d", hold_cycles);
            "I": begin
               got = $sscanf(body, "%d", n);
               repeat (n + $urandom % 3) drive_cycle(1'b0, 1'b1, 1'b0, '0, '0);
            end
            "B": begin
               got = $sscanf(body, "%h %h %h %h %h", v, r, l, keep, data);
               // Random stall, same beat with TREADY low
               if (v != 0 && r != 0 && $urandom % 4 == 0) begin
                  drive_cycle(1'b1, 1'b0, l[0], keep, data);
               end
               drive_cycle(v[0], r[0], l[0], keep, data);
               if (v != 0 && r != 0 && flag != 0) begin
                  // Even beat opens a word in the lower half
                  if (beats % 2 == 0) begin
                     word = {{`SNOOP_DATA_W{1'b0}}, data};
                  end else begin
                     word[`MEM_DATA_W-1:`SNOOP_DATA_W] = data;
                  end
                  len += keep_bytes(keep);
                  beats++;
                  if (beats % 2 == 0 || l != 0) begin
                     exp_words.push_back(word);
                     words++;
                  end
                  if (l != 0) begin
                     exp_nwords.push_back(words);
                     exp_len.push_back(len);
                  end
               end else if (v != 0 && r != 0 && l != 0) begin
                  // Dropped packet ends, counter moves one cycle later
                  drops++;
                  drive_cycle(1'b0, 1'b1, 1'b0, '0, '0);
                  check_value("drop_count_o", drop_count_o, drops);
               end
            end
            default: begin
               errors++;
               $display("Unknown stimulus line: %s", stim_lines[i]);
            end
         endcase
      end
   endtask

   // Packet reader: check length, wait the hold, read back, release
   initial begin : reader
      int len;
      int words;
      int delay;
      forever begin
         @(negedge clk);
         if (pkt_valid_o === 1'b1) begin
            reader_busy = 1'b1;
            words = 0;
            if (exp_len.size() == 0) begin
               errors++;
               $display("Buffer holds a packet that should have been dropped");
            end else begin
               len = exp_len.pop_front();
               words = exp_nwords.pop_front();
               check_value("pkt_len_o", pkt_len_o, len);
            end
            delay = hold_cycles;
            hold_cycles = 0;
            repeat (delay) @(negedge clk);
            // Read after the hold so any write into the held buffer shows
            for (int w = 0; w < words; w++) begin
               rd_addr_i = mem_addr_t'(w);
               @(negedge clk);
               check_value("rd_data_o", rd_data_o, exp_words.pop_front());
            end
            pkt_release_i = 1'b1;
            @(posedge clk);
            buf_released = 1'b1;
            @(negedge clk);
            pkt_release_i = 1'b0;
            reader_busy = 1'b0;
         end
      end
   end

   initial begin : main
      int budget;
      int drops;
      int unsigned first_draw;
      rst = 1'b1;
      s_tdata_i = '0;
      s_tkeep_i = '0;
      s_tvalid_i = 1'b0;
      s_tready_i = 1'b0;
      s_tlast_i = 1'b0;
      rd_addr_i = '0;
      pkt_release_i = 1'b0;
      // Seed the generator once for the run
      first_draw = $urandom(32'hbe7f);
      load_stimulus(budget);
      if (stim_lines.size() == 0) begin
         $display("No stimulus lines read, nothing to run");
         $display("TB FAILED");
         $finish;
      end else begin
         cycle_limit = 4 * budget + 200;
         repeat (3) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         check_value("pkt_valid_o", pkt_valid_o, 0);
         check_value("drop_count_o", drop_count_o, 0);
         run_stimulus(drops);
         // Reader drains every captured packet
         while (exp_len.size() != 0 || reader_busy) @(negedge clk);
         check_value("drop_count_o", drop_count_o, drops);
         check_value("pkt_valid_o", pkt_valid_o, 0);
         $display("Dropped packets: %0d, errors: %0d", drops, errors);
         if (errors == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end
endmodule
